// File: wb_pkg.sv
package wb_pkg;

  // Bus widths
  typedef logic [31:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;
  typedef logic [3:0]  wb_sel_t;

  localparam int N_SLAVES = 2;
  typedef logic [N_SLAVES-1:0] slv_vec_t;

  // Slave slots, also the index into the window tables
  localparam int SLV_REG = 0;
  localparam int SLV_ID  = 1;

  // Inclusive byte windows of each slave
  localparam wb_adr_t SLAVE_BASE [N_SLAVES] = '{
    SLV_REG: 32'h0000_1000,
    SLV_ID:  32'h0000_2000
  };
  localparam wb_adr_t SLAVE_HIGH [N_SLAVES] = '{
    SLV_REG: 32'h0000_10FF,
    SLV_ID:  32'h0000_203F
  };

  // Register bank decodes only the bottom of its window
  localparam int REG_WORDS = 16;
  localparam int ID_WORDS  = 16;
  typedef logic [$clog2(REG_WORDS)-1:0] reg_idx_t;
  typedef logic [$clog2(ID_WORDS)-1:0]  id_idx_t;

  // Vendor, version, slave count, two build words, rest zero
  localparam wb_dat_t ID_ROM [ID_WORDS] = '{
    0:       32'h0000_57B3,
    1:       32'h0001_0002,
    2:       32'(N_SLAVES),
    3:       32'h0000_00A7,
    4:       32'h0000_0C31,
    default: 32'h0000_0000
  };

  localparam int TIMEOUT_CYCLES = 16;
  typedef logic [$clog2(TIMEOUT_CYCLES+1)-1:0] timer_cnt_t;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_sel_t sel;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  typedef struct packed {
    wb_dat_t dat;
    logic    ack;
    logic    err;
  } wb_rsp_t;

  typedef wb_rsp_t [N_SLAVES-1:0] slv_rsp_t;

  typedef enum logic [1:0] {ARB_IDLE, ARB_WAIT, ARB_DONE} arb_state_t;

endpackage

// File: wb_addr_decode.sv
`timescale 1ns/1ns

module wb_addr_decode
  import wb_pkg::*;
(
  input  logic     wb_clk_i,
  input  wb_adr_t  adr_i,
  output slv_vec_t hit_o,
  output wb_adr_t  offset_o
);

  slv_vec_t in_win;
  wb_adr_t  base_sel;

  // Window compare for every slave in parallel
  always_comb begin
    for (int i = 0; i < N_SLAVES; i++) begin
      in_win[i] = (adr_i >= SLAVE_BASE[i]) && (adr_i <= SLAVE_HIGH[i]);
    end
  end

  // Base of the window that hit, zero on a miss
  always_comb begin
    base_sel = '0;
    for (int i = 0; i < N_SLAVES; i++) begin
      if (in_win[i]) begin
        base_sel = SLAVE_BASE[i];
      end
    end
  end

  // Hit and offset share one register stage
  always_ff @(posedge wb_clk_i) begin
    hit_o    <= in_win;
    offset_o <= adr_i - base_sel;
  end

  // Windows in the map must never overlap
  a_hit_onehot: assert property (
    @(posedge wb_clk_i) !$isunknown(hit_o) |-> $onehot0(hit_o)
  ) else $error("wb_addr_decode: more than one window hit, hit_o=%b", hit_o);

endmodule

// File: wb_bus_timer.sv
`timescale 1ns/1ns

module wb_bus_timer
  import wb_pkg::*;
(
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic clear_i,
  output logic expired_o
);

  timer_cnt_t cnt;

  assign expired_o = (cnt >= timer_cnt_t'(TIMEOUT_CYCLES));

  // Saturates at the limit so expiry holds until cleared
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clear_i) begin
      cnt <= '0;
    end else if (!expired_o) begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: wbs_arbiter.sv
`timescale 1ns/1ns

module wbs_arbiter
  import wb_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  input  wb_req_t  wbm_req_i,
  output wb_rsp_t  wbm_rsp_o,
  output wb_req_t  wbs_req_o,
  output slv_vec_t wbs_cyc_o,
  input  slv_rsp_t wbs_rsp_i
);

  // Input stage
  wb_req_t    req_q;
  slv_rsp_t   slv_q;

  // Request payload and strobe lined up with the decode result
  wb_req_t    req_d;
  logic       stb_d;

  slv_vec_t   hit;
  wb_adr_t    offset;
  logic       expired;

  arb_state_t state;
  slv_vec_t   active;
  slv_vec_t   cyc_q;
  wb_req_t    fwd_q;
  wb_rsp_t    act_rsp;
  logic       rsp_ack_q;
  logic       rsp_err_q;
  wb_dat_t    rsp_dat_q;

  always_ff @(posedge wb_clk_i) begin
    req_q <= wbm_req_i;
    slv_q <= wbs_rsp_i;
    req_d <= req_q;
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      stb_d <= 1'b0;
    end else begin
      stb_d <= req_q.cyc & req_q.stb;
    end
  end

  wb_addr_decode i_decode (
    .wb_clk_i (wb_clk_i),
    .adr_i    (req_q.adr),
    .hit_o    (hit),
    .offset_o (offset)
  );

  wb_bus_timer i_timer (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .clear_i   (state != ARB_WAIT),
    .expired_o (expired)
  );

  // Only the latched slave can drive the return path
  always_comb begin
    act_rsp = '0;
    for (int i = 0; i < N_SLAVES; i++) begin
      if (active[i]) begin
        act_rsp = act_rsp | slv_q[i];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state     <= ARB_IDLE;
      active    <= '0;
      cyc_q     <= '0;
      rsp_ack_q <= 1'b0;
      rsp_err_q <= 1'b0;
    end else begin
      rsp_ack_q <= 1'b0;
      rsp_err_q <= 1'b0;
      case (state)
        ARB_IDLE: begin
          if (stb_d) begin
            if (hit == '0) begin
              // Nothing mapped here
              rsp_err_q <= 1'b1;
              state     <= ARB_DONE;
            end else begin
              active <= hit;
              cyc_q  <= hit;
              state  <= ARB_WAIT;
            end
          end
        end
        ARB_WAIT: begin
          if (act_rsp.ack || act_rsp.err) begin
            rsp_ack_q <= act_rsp.ack;
            rsp_err_q <= act_rsp.err;
            cyc_q     <= '0;
            state     <= ARB_DONE;
          end else if (expired) begin
            rsp_err_q <= 1'b1;
            cyc_q     <= '0;
            state     <= ARB_DONE;
          end
        end
        ARB_DONE: begin
          // Master must drop stb before a new access is taken
          if (!stb_d) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Slave request fields are latched at the start of an access
  always_ff @(posedge wb_clk_i) begin
    if (state == ARB_IDLE && stb_d) begin
      fwd_q.cyc <= 1'b0;
      fwd_q.stb <= 1'b0;
      fwd_q.we  <= req_d.we;
      fwd_q.sel <= req_d.sel;
      fwd_q.adr <= offset;
      fwd_q.dat <= req_d.dat;
    end
    rsp_dat_q <= act_rsp.dat;
  end

  // Output stage
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wbm_rsp_o <= '0;
      wbs_cyc_o <= '0;
    end else begin
      wbm_rsp_o <= '{dat: rsp_dat_q, ack: rsp_ack_q, err: rsp_err_q};
      wbs_cyc_o <= cyc_q;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    wbs_req_o <= fwd_q;
  end

  a_cyc_onehot: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) $onehot0(wbs_cyc_o)
  ) else $error("wbs_arbiter: more than one slave selected, cyc=%b", wbs_cyc_o);

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(wbm_rsp_o.ack && wbm_rsp_o.err)
  ) else $error("wbs_arbiter: ack and err high together");

endmodule

// File: wb_reg_slave.sv
`timescale 1ns/1ns

module wb_reg_slave
  import wb_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    cyc_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  wb_dat_t  regs [REG_WORDS];
  reg_idx_t idx;
  logic     in_range;
  logic     answered;
  logic     take;
  logic     ack_q;
  wb_dat_t  dat_q;

  assign idx      = req_i.adr[2 +: $bits(reg_idx_t)];
  // Upper part of the window is left undecoded
  assign in_range = (req_i.adr < wb_adr_t'(REG_WORDS * 4));
  assign take     = cyc_i && !answered && in_range;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      answered <= 1'b0;
      ack_q    <= 1'b0;
      for (int w = 0; w < REG_WORDS; w++) begin
        regs[w] <= '0;
      end
    end else begin
      ack_q <= take;
      if (!cyc_i) begin
        answered <= 1'b0;
      end else if (take) begin
        answered <= 1'b1;
      end
      if (take && req_i.we) begin
        for (int b = 0; b < $bits(wb_sel_t); b++) begin
          if (req_i.sel[b]) begin
            regs[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data is the word as stored before any write in the same access
  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      dat_q <= regs[idx];
    end
  end

  assign rsp_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

  a_single_ack: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) rsp_o.ack |=> !rsp_o.ack
  ) else $error("wb_reg_slave: ack longer than one cycle");

endmodule

// File: wb_id_slave.sv
`timescale 1ns/1ns

module wb_id_slave
  import wb_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    cyc_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  id_idx_t idx;
  logic    answered;
  logic    take;
  logic    ack_q;
  logic    err_q;
  wb_dat_t dat_q;

  // Whole window maps onto the table
  assign idx  = req_i.adr[2 +: $bits(id_idx_t)];
  assign take = cyc_i && !answered;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      answered <= 1'b0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      ack_q    <= take && !req_i.we;
      err_q    <= take && req_i.we;
      answered <= cyc_i && (answered || take);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      dat_q <= ID_ROM[idx];
    end
  end

  assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

  // Reply follows a rising cyc by one cycle
  a_reply: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) $rose(cyc_i) |=> (rsp_o.ack || rsp_o.err)
  ) else $error("wb_id_slave: no reply one cycle after cyc");

endmodule

// File: wb_subsystem_top.sv
`timescale 1ns/1ns

module wb_subsystem_top
  import wb_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  wb_req_t wbm_req_i,
  output wb_rsp_t wbm_rsp_o
);

  // Shared slave request with a one-hot select
  wb_req_t  wbs_req;
  slv_vec_t wbs_cyc;
  slv_rsp_t wbs_rsp;

  wbs_arbiter i_arbiter (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_req_i (wbm_req_i),
    .wbm_rsp_o (wbm_rsp_o),
    .wbs_req_o (wbs_req),
    .wbs_cyc_o (wbs_cyc),
    .wbs_rsp_i (wbs_rsp)
  );

  wb_reg_slave i_reg_slave (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (wbs_cyc[SLV_REG]),
    .req_i    (wbs_req),
    .rsp_o    (wbs_rsp[SLV_REG])
  );

  wb_id_slave i_id_slave (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (wbs_cyc[SLV_ID]),
    .req_i    (wbs_req),
    .rsp_o    (wbs_rsp[SLV_ID])
  );

  // A slave only speaks while the arbiter still selects it
  a_reg_reply_in_cyc: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (wbs_rsp[SLV_REG].ack || wbs_rsp[SLV_REG].err) |-> wbs_cyc[SLV_REG]
  ) else $error("wb_subsystem_top: register bank replied outside its cyc");

  a_id_reply_in_cyc: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (wbs_rsp[SLV_ID].ack || wbs_rsp[SLV_ID].err) |-> wbs_cyc[SLV_ID]
  ) else $error("wb_subsystem_top: identification block replied outside its cyc");

endmodule

// File: tb_wb_tasks.svh
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// Totals for the run and the share of the test in progress
int checks_total;
int errors_total;
int tests_done;
int checks_test;
int errors_test;

task automatic expect_bit(input string name, input logic exp, input logic act);
  checks_test++;
  assert (act === exp) else begin
    $display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
    errors_test++;
  end
endtask

task automatic expect_word(input string name, input wb_dat_t exp, input wb_dat_t act);
  checks_test++;
  assert (act === exp) else begin
    $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    errors_test++;
  end
endtask

task automatic close_test(input string name);
  $display("test %-10s %0d checks, %0d errors", name, checks_test, errors_test);
  checks_total += checks_test;
  errors_total += errors_test;
  tests_done++;
  checks_test = 0;
  errors_test = 0;
endtask

// Called on a falling edge; returns one falling edge after stb is dropped
task automatic do_access(input logic we, input wb_sel_t sel, input wb_adr_t adr,
                         input wb_dat_t dat, output logic ack, output logic err,
                         output wb_dat_t rdat, output int cycles);
  logic done;
  done   = 1'b0;
  ack    = 1'b0;
  err    = 1'b0;
  rdat   = '0;
  cycles = 0;
  wbm_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
  while (!done && cycles < TIMEOUT_CYCLES + 20) begin
    @(negedge wb_clk);
    cycles++;
    if (wbm_rsp.ack || wbm_rsp.err) begin
      done = 1'b1;
      ack  = wbm_rsp.ack;
      err  = wbm_rsp.err;
      rdat = wbm_rsp.dat;
    end
  end
  checks_test++;
  assert (done) else begin
    $display("No reply at %0t ns: neither ack nor err came for address %h", $time, adr);
    errors_test++;
  end
  wbm_req.cyc = 1'b0;
  wbm_req.stb = 1'b0;
  @(negedge wb_clk);
endtask

`endif

// File: tb_wb_subsystem.sv
`timescale 1ns/1ns

module tb_wb_subsystem
  import wb_pkg::*;
();

  logic    wb_clk;
  logic    wb_rst;
  wb_req_t wbm_req;
  wb_rsp_t wbm_rsp;

  logic [31:0] rng_state;
  wb_dat_t     model_regs [REG_WORDS];

  `include "tb_wb_tasks.svh"

  wb_subsystem_top i_wb_subsystem_top (
    .wb_clk_i  (wb_clk),
    .wb_rst_i  (wb_rst),
    .wbm_req_i (wbm_req),
    .wbm_rsp_o (wbm_rsp)
  );

  initial begin
    wb_clk = 1'b0;
    forever #10 wb_clk = ~wb_clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Only the byte lanes with sel set take the new data
  function automatic wb_dat_t merge_lanes(input wb_dat_t old, input wb_dat_t wdat,
                                          input wb_sel_t sel);
    wb_dat_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = wdat[8*b +: 8];
    end
    return res;
  endfunction

  function automatic wb_adr_t word_adr(input int slv, input int idx);
    return SLAVE_BASE[slv] + wb_adr_t'(idx * 4);
  endfunction

  // Words of the register window past the decoded ones
  function automatic wb_adr_t hole_adr(input logic [31:0] r);
    int win_words;
    win_words = int'((SLAVE_HIGH[SLV_REG] - SLAVE_BASE[SLV_REG] + 1) / 4);
    return word_adr(SLV_REG, REG_WORDS + int'(r[31:16]) % (win_words - REG_WORDS));
  endfunction

  function automatic wb_adr_t miss_adr(input logic [31:0] r);
    case (r[13:12])
      2'd0:    return {1'b1, r[30:2], 2'b00};
      2'd1:    return SLAVE_HIGH[SLV_REG] + 1 + {22'd0, r[9:2], 2'b00};
      2'd2:    return SLAVE_HIGH[SLV_ID] + 1 + {22'd0, r[9:2], 2'b00};
      default: return {20'd0, r[11:2], 2'b00};
    endcase
  endfunction

  task automatic access_and_check(input logic we, input wb_sel_t sel, input wb_adr_t adr,
                                  input wb_dat_t dat, input logic exp_ack,
                                  input wb_dat_t exp_dat);
    logic    ack;
    logic    err;
    wb_dat_t rdat;
    int      cycles;
    do_access(we, sel, adr, dat, ack, err, rdat, cycles);
    expect_bit("wbm_rsp_o.ack", exp_ack, ack);
    expect_bit("wbm_rsp_o.err", !exp_ack, err);
    if (exp_ack && !we) expect_word("wbm_rsp_o.dat", exp_dat, rdat);
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < REG_WORDS; i++) begin
      access_and_check(1'b0, 4'hF, word_adr(SLV_REG, i), '0, 1'b1, model_regs[i]);
    end
  endtask

  // Target 0 register bank, 1 identification block, 2 hole, 3 miss
  task automatic mixed_access(input int target);
    logic [31:0] r;
    logic        we;
    wb_sel_t     sel;
    wb_dat_t     dat;
    int          idx;
    r   = next_rand();
    we  = r[0];
    sel = r[7:4];
    idx = int'(r[11:8]);
    dat = next_rand();
    case (target)
      0: begin
        access_and_check(we, sel, word_adr(SLV_REG, idx), dat, 1'b1, model_regs[idx]);
        if (we) model_regs[idx] = merge_lanes(model_regs[idx], dat, sel);
      end
      1:       access_and_check(we, sel, word_adr(SLV_ID, idx), dat, !we, ID_ROM[idx]);
      2:       access_and_check(we, sel, hole_adr(r), dat, 1'b0, '0);
      default: access_and_check(we, sel, miss_adr(r), dat, 1'b0, '0);
    endcase
  endtask

  initial begin
    logic        ack;
    logic        err;
    wb_dat_t     rdat;
    int          cycles;
    int          idx;
    rng_state = 32'd93348;
    wb_rst    = 1'b1;
    wbm_req   = '0;
    for (int i = 0; i < REG_WORDS; i++) model_regs[i] = '0;
    repeat (3) @(posedge wb_clk);
    @(negedge wb_clk);
    wb_rst = 1'b0;
    @(negedge wb_clk);

    expect_bit("wbm_rsp_o.ack", 1'b0, wbm_rsp.ack);
    expect_bit("wbm_rsp_o.err", 1'b0, wbm_rsp.err);
    check_all_regs();
    close_test("reset");

    repeat (40) mixed_access(0);
    check_all_regs();
    close_test("regbank");

    for (int i = 0; i < REG_WORDS; i++) begin
      access_and_check(1'b0, 4'hF, word_adr(SLV_ID, i), '0, 1'b1, ID_ROM[i]);
    end
    idx = int'(next_rand() % REG_WORDS);
    access_and_check(1'b1, 4'hF, word_adr(SLV_ID, idx), next_rand(), 1'b0, '0);
    access_and_check(1'b0, 4'hF, word_adr(SLV_ID, idx), '0, 1'b1, ID_ROM[idx]);
    close_test("id");

    repeat (12) mixed_access(3);
    check_all_regs();
    close_test("miss");

    // Writes into the hole must leave the bank alone
    repeat (4) begin
      do_access(1'b1, 4'hF, hole_adr(next_rand()), next_rand(), ack, err, rdat, cycles);
      expect_bit("wbm_rsp_o.ack", 1'b0, ack);
      expect_bit("wbm_rsp_o.err", 1'b1, err);
      checks_test++;
      assert (cycles >= TIMEOUT_CYCLES) else begin
        $display("Timeout error at %0t ns came after %0d cycles, before the limit of %0d",
                 $time, cycles, TIMEOUT_CYCLES);
        errors_test++;
      end
    end
    check_all_regs();
    close_test("timeout");

    repeat (300) mixed_access(int'(next_rand() % 4));
    close_test("random");

    $display("tests %0d, checks %0d, errors %0d", tests_done, checks_total, errors_total);
    if (errors_total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
wb_pkg.sv
wb_addr_decode.sv
wb_bus_timer.sv
wbs_arbiter.sv
wb_reg_slave.sv
wb_id_slave.sv
wb_subsystem_top.sv
tb_wb_subsystem.sv
